// ==== filelist.f ====
source/sdPkg.sv
source/crc7.sv
source/crc16.sv
source/sdCmdTx.sv
source/sdRespRx.sv
source/sdDatRx.sv
source/sdReadCtrl.sv
source/sdReadCore.sv
tb/sdCardModel.sv
tb/tbSdReadCore.sv

// ==== Bender.yml ====
package:
  name: sdReadCore

sources:
  - source/sdPkg.sv
  - source/crc7.sv
  - source/crc16.sv
  - source/sdCmdTx.sv
  - source/sdRespRx.sv
  - source/sdDatRx.sv
  - source/sdReadCtrl.sv
  - source/sdReadCore.sv
  - target: test
    files:
      - tb/sdCardModel.sv
      - tb/tbSdReadCore.sv

// ==== tb/tbSdReadCore.sv ====
// Testbench for the SD read core with clock, reset, read stimulus,
// assertion checks and per-test reporting
`default_nettype none

module tbSdReadCore;
    timeunit 1ns;
    timeprecision 100ps;
    import sdPkg::*;

    localparam int blockWords = 8;
    localparam int poolWords = 64;
    localparam int waitLimit = 400;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cmdTrigger;
    logic [31:0]             cmdAddr;
    logic                    cmdAccepted;
    logic [wordBits-1:0]     dataOut;
    logic                    dataOutValid;
    logic                    err;
    logic                    sdCmdIn;
    sdCmdLine                sdCmd;
    logic [datLanes-1:0]     sdDatIn;

    logic [poolWords*16-1:0] wordPool;
    logic                    respCrcFault;
    logic                    datCrcFault;
    logic [47:0]             frame;
    logic [7:0]              frameLen;
    logic [6:0]              frameCrcRef;
    logic                    frameSeen;
    logic                    stopDone;

    integer      seed = 32'h14cf_365d;
    int          errorCount = 0;
    int          testCount = 0;
    int          failCount = 0;
    int          acceptCount = 0;
    int          wordCount = 0;
    int          stopCount = 0;
    int          wordBase = 0;
    logic [31:0] reqAddr = '0;
    logic        expectStop = 1'b0;
    logic        rstSeen = 1'b0;

    always #4 clk = ~clk;

    sdReadCore #(
        .blockWords (blockWords)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .cmdTrigger   (cmdTrigger),
        .cmdAddr      (cmdAddr),
        .cmdAccepted  (cmdAccepted),
        .dataOut      (dataOut),
        .dataOutValid (dataOutValid),
        .err          (err),
        .sdCmdIn      (sdCmdIn),
        .sdCmd        (sdCmd),
        .sdDatIn      (sdDatIn)
    );

    sdCardModel #(
        .blockWords (blockWords),
        .poolWords  (poolWords)
    ) card (
        .clk          (clk),
        .cmdLine      (sdCmd),
        .cmdResp      (sdCmdIn),
        .dat          (sdDatIn),
        .wordPool     (wordPool),
        .respCrcFault (respCrcFault),
        .datCrcFault  (datCrcFault),
        .frame        (frame),
        .frameLen     (frameLen),
        .frameCrcRef  (frameCrcRef),
        .frameSeen    (frameSeen),
        .stopDone     (stopDone)
    );

    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic abortRun(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        $display("test failed");
        $finish;
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("Test %0d %s: PASS", testCount, name);
        end else begin
            failCount++;
            $display("Test %0d %s: FAIL (%0d errors)", testCount, name,
                     errorCount - startErrors);
        end
    endtask

    task automatic applyReset();
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
    endtask

    // One CMD18 transfer, trigger held until the wanted blocks are accepted
    task automatic runRead(input logic [31:0] addr, input int blocks);
        int seen;
        int cycles;
        int acceptStart;
        int stopStart;
        seen = 0;
        cycles = 0;
        acceptStart = acceptCount;
        stopStart = stopCount;
        reqAddr = addr;
        wordBase = wordCount;
        cmdAddr <= addr;
        cmdTrigger <= 1'b1;
        while (seen < blocks && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
            if (cmdAccepted) begin
                seen++;
            end
        end
        cmdTrigger <= 1'b0;
        if (seen < blocks) begin
            abortRun("cmdAccepted");
        end
        cycles = 0;
        while (!stopDone && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (!stopDone) begin
            abortRun("the CMD12 response");
        end
        // Response receiver and FSM settle back to idle
        repeat (2) @(posedge clk);
        assert (acceptCount - acceptStart == blocks)
        else reportMismatch("wrong number of cmdAccepted pulses");
        assert (wordCount - wordBase == blocks * blockWords)
        else reportMismatch("wrong number of dataOutValid pulses");
        assert (stopCount - stopStart == 1)
        else reportMismatch("missing CMD12 frame");
    endtask

    // ============================================================
    // Checkers
    // ============================================================

    always @(posedge clk) begin : checks
        logic [15:0] expWord;
        rstSeen <= rst;
        if (rstSeen) begin
            assert (!cmdAccepted && !dataOutValid && !err && !sdCmd.cmdOutActive)
            else reportMismatch("outputs not idle during or after reset");
        end
        if (cmdAccepted) begin
            acceptCount <= acceptCount + 1;
        end
        if (dataOutValid) begin
            expWord = wordPool[((wordCount - wordBase) % poolWords) * 16 +: 16];
            assert (dataOut == expWord)
            else reportMismatch($sformatf("dataOut %h, expected %h", dataOut, expWord));
            wordCount <= wordCount + 1;
        end
        if (frameSeen) begin
            assert (frameLen == 8'd48)
            else reportMismatch($sformatf("cmdOutActive lasted %0d cycles", frameLen));
            assert (frame[47:46] == 2'b01 && frame[0])
            else reportMismatch("bad start, transmission or end bit in command");
            assert (frame[7:1] == frameCrcRef)
            else reportMismatch($sformatf("command CRC7 %h, expected %h",
                                          frame[7:1], frameCrcRef));
            if (expectStop) begin
                assert (frame[45:40] == 6'd12 && frame[39:8] == 32'd0)
                else reportMismatch("expected CMD12 with argument 0");
                stopCount <= stopCount + 1;
            end else begin
                assert (frame[45:40] == 6'd18 && frame[39:8] == reqAddr)
                else reportMismatch("expected CMD18 with the requested address");
            end
            expectStop <= !expectStop;
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================

    initial begin
        logic [31:0] r;
        int          i;
        int          startErr;
        rst = 1'b1;
        cmdTrigger = 1'b0;
        cmdAddr = '0;
        respCrcFault = 1'b0;
        datCrcFault = 1'b0;
        for (i = 0; i < poolWords; i++) begin
            r = $random(seed);
            wordPool[i * 16 +: 16] = r[15:0];
        end

        startErr = errorCount;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        finishTest("reset state", startErr);

        startErr = errorCount;
        runRead(32'h0000_1234, 1);
        assert (!err) else reportMismatch("err set on a clean single-block read");
        finishTest("command frame and single-block read", startErr);

        startErr = errorCount;
        runRead(32'h00ab_cdef, 3);
        runRead(32'h0000_0040, 1);
        assert (!err) else reportMismatch("err set on a clean multi-block read");
        finishTest("multi-block read and new request", startErr);

        startErr = errorCount;
        datCrcFault <= 1'b1;
        runRead(32'h0000_0200, 1);
        datCrcFault <= 1'b0;
        assert (err) else reportMismatch("err not set by a data CRC fault");
        repeat (20) begin
            @(posedge clk);
            assert (err) else reportMismatch("err dropped before reset");
        end
        applyReset();
        assert (!err) else reportMismatch("err not cleared by reset");
        finishTest("data CRC fault", startErr);

        startErr = errorCount;
        respCrcFault <= 1'b1;
        runRead(32'h0000_0300, 1);
        respCrcFault <= 1'b0;
        assert (err) else reportMismatch("err not set by a response CRC fault");
        applyReset();
        assert (!err) else reportMismatch("err not cleared by reset");
        finishTest("response CRC fault", startErr);

        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/sdCardModel.sv ====
// Behavioral SD card for the read path, R1 responses and 4-bit data blocks
// with per-lane CRC16, plus response and data CRC fault injection
`default_nettype none

module sdCardModel #(
    parameter int blockWords = 8,
    parameter int poolWords = 64
) (
    input  logic                    clk,
    input  sdPkg::sdCmdLine         cmdLine,
    output logic                    cmdResp,
    output logic [3:0]              dat,
    input  logic [poolWords*16-1:0] wordPool,
    input  logic                    respCrcFault,
    input  logic                    datCrcFault,
    output logic [47:0]             frame,
    output logic [7:0]              frameLen,
    output logic [6:0]              frameCrcRef,
    output logic                    frameSeen,
    output logic                    stopDone
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdPkg::*;

    // Start nibble, data, 16 CRC nibbles and the end nibble
    localparam int seqLen = 4 * blockWords + crc16Bits + 2;

    logic        cmdBit = 1'b1;
    logic [3:0]  datNib = 4'hF;
    logic        stopPulse = 1'b0;
    logic        framePulse = 1'b0;
    logic [47:0] shiftIn;
    logic [7:0]  bitCnt = '0;
    logic        readActive = 1'b0;
    int          wordIdx = 0;
    int          respDelay = 0;

    assign cmdResp = cmdBit;
    assign dat = datNib;
    assign stopDone = stopPulse;
    assign frameSeen = framePulse;

    function automatic logic [6:0] crc7Of(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        int         i;
        c = '0;
        for (i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    function automatic logic [15:0] crc16Step(input logic [15:0] c, input logic b);
        logic fb;
        fb = b ^ c[15];
        return {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    endfunction

    // ============================================================
    // Command capture
    // ============================================================

    always @(posedge clk) begin
        framePulse <= 1'b0;
        if (cmdLine.cmdOutActive) begin
            shiftIn <= {shiftIn[46:0], cmdLine.cmdOut};
            bitCnt <= bitCnt + 1'b1;
        end else if (bitCnt != '0) begin
            frame <= shiftIn;
            frameLen <= bitCnt;
            frameCrcRef <= crc7Of(shiftIn[47:8]);
            framePulse <= 1'b1;
            bitCnt <= '0;
        end
    end

    // R1 with echoed index and card status
    task automatic sendResponse(input logic [5:0] idx);
        logic [47:0] resp;
        int          i;
        resp[47:8] = {2'b00, idx, 32'h0000_0900};
        resp[7:1] = crc7Of(resp[47:8]) ^ {6'd0, respCrcFault && idx == cmdReadMultiple};
        resp[0] = 1'b1;
        repeat (respDelay) @(posedge clk);
        for (i = 47; i >= 0; i--) begin
            cmdBit <= resp[i];
            @(posedge clk);
        end
        cmdBit <= 1'b1;
        respDelay = (respDelay + 1) % 4;
        if (idx == cmdStopTransmission) begin
            stopPulse <= 1'b1;
            @(posedge clk);
            stopPulse <= 1'b0;
        end
    endtask

    always begin
        @(posedge clk);
        if (framePulse) begin
            readActive <= frame[45:40] == cmdReadMultiple;
            sendResponse(frame[45:40]);
        end
    end

    // ============================================================
    // Data blocks
    // ============================================================

    task automatic sendBlock();
        logic [3:0]  seq [seqLen];
        logic [15:0] laneCrc [datLanes];
        logic [15:0] word;
        logic [3:0]  nib;
        int          w;
        int          k;
        int          l;
        int          n;
        for (l = 0; l < datLanes; l++) begin
            laneCrc[l] = '0;
        end
        seq[0] = 4'h0;
        for (w = 0; w < blockWords; w++) begin
            word = wordPool[(wordIdx % poolWords) * 16 +: 16];
            wordIdx++;
            for (k = 0; k < 4; k++) begin
                nib = word[15 - 4 * k -: 4];
                seq[1 + 4 * w + k] = nib;
                for (l = 0; l < datLanes; l++) begin
                    laneCrc[l] = crc16Step(laneCrc[l], nib[l]);
                end
            end
        end
        for (k = 0; k < crc16Bits; k++) begin
            for (l = 0; l < datLanes; l++) begin
                nib[l] = laneCrc[l][15 - k];
            end
            // Fault flips the CRC MSB on DAT2
            if (k == 0 && datCrcFault) begin
                nib[2] = !nib[2];
            end
            seq[1 + 4 * blockWords + k] = nib;
        end
        seq[seqLen - 1] = 4'hF;
        repeat (4) begin
            datNib <= 4'hF;
            @(posedge clk);
        end
        // CMD12 aborts the block in flight
        for (n = 0; n < seqLen && readActive; n++) begin
            datNib <= seq[n];
            @(posedge clk);
        end
        datNib <= 4'hF;
    endtask

    always begin
        @(posedge clk);
        if (!readActive) begin
            wordIdx = 0;
        end else begin
            sendBlock();
        end
    end

endmodule

`default_nettype wire

// ==== source/sdReadCore.sv ====
// Top level of the SD read core, controller with command and data paths
`default_nettype none

module sdReadCore #(
    parameter int blockWords = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmdTrigger,
    input  logic [31:0]                cmdAddr,
    output logic                       cmdAccepted,
    output logic [sdPkg::wordBits-1:0] dataOut,
    output logic                       dataOutValid,
    output logic                       err,
    input  logic                       sdCmdIn,
    output sdPkg::sdCmdLine            sdCmd,
    input  logic [sdPkg::datLanes-1:0] sdDatIn
);
    import sdPkg::*;

    logic      txStart;
    logic      txDone;
    sdCmdFrame txFrame;
    logic      respArm;
    logic      respDone;
    logic      respErr;
    logic      datArm;
    logic      blockDone;
    logic      datErr;

    sdReadCtrl ctrl (
        .clk         (clk),
        .rst         (rst),
        .cmdTrigger  (cmdTrigger),
        .cmdAddr     (cmdAddr),
        .cmdAccepted (cmdAccepted),
        .txStart     (txStart),
        .txFrame     (txFrame),
        .txDone      (txDone),
        .respArm     (respArm),
        .respDone    (respDone),
        .respErr     (respErr),
        .datArm      (datArm),
        .blockDone   (blockDone),
        .datErr      (datErr),
        .err         (err)
    );

    sdCmdTx cmdTx (
        .clk     (clk),
        .rst     (rst),
        .txStart (txStart),
        .txFrame (txFrame),
        .txDone  (txDone),
        .cmdLine (sdCmd)
    );

    sdRespRx respRx (
        .clk      (clk),
        .rst      (rst),
        .respArm  (respArm),
        .cmdIn    (sdCmdIn),
        .respDone (respDone),
        .respErr  (respErr)
    );

    sdDatRx #(
        .blockWords (blockWords)
    ) datRx (
        .clk          (clk),
        .rst          (rst),
        .datArm       (datArm),
        .datIn        (sdDatIn),
        .dataOut      (dataOut),
        .dataOutValid (dataOutValid),
        .blockDone    (blockDone),
        .datErr       (datErr)
    );

endmodule

`default_nettype wire

// ==== source/sdReadCtrl.sv ====
// Read sequencing FSM, CMD18 then blocks, CMD12 when the client lets go
`default_nettype none

module sdReadCtrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmdTrigger,
    input  logic [31:0]      cmdAddr,
    output logic             cmdAccepted,
    output logic             txStart,
    output sdPkg::sdCmdFrame txFrame,
    input  logic             txDone,
    output logic             respArm,
    input  logic             respDone,
    input  logic             respErr,
    output logic             datArm,
    input  logic             blockDone,
    input  logic             datErr,
    output logic             err
);
    import sdPkg::*;

    typedef enum logic [2:0] {
        idle,
        sendRead,
        readBlock,
        sendStop,
        waitStopResp
    } ctrlStateType;

    ctrlStateType state;
    logic [31:0]  addrReg;
    logic         respSeen;

    // Frame follows the state that issued txStart
    always_comb begin
        txFrame.index = (state == sendStop) ? cmdStopTransmission : cmdReadMultiple;
        txFrame.arg = (state == sendStop) ? 32'd0 : addrReg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            respSeen <= 1'b0;
            cmdAccepted <= 1'b0;
            txStart <= 1'b0;
            respArm <= 1'b0;
            datArm <= 1'b0;
            err <= 1'b0;
        end else begin
            cmdAccepted <= 1'b0;
            txStart <= 1'b0;
            respArm <= 1'b0;
            datArm <= 1'b0;
            case (state)
                idle: begin
                    if (cmdTrigger) begin
                        cmdAccepted <= 1'b1;
                        txStart <= 1'b1;
                        state <= sendRead;
                    end
                end
                // Response and first block are received in parallel
                sendRead: begin
                    if (txDone) begin
                        respArm <= 1'b1;
                        datArm <= 1'b1;
                        respSeen <= 1'b0;
                        state <= readBlock;
                    end
                end
                readBlock: begin
                    if (respDone) begin
                        respSeen <= 1'b1;
                    end
                    if (blockDone && (respSeen || respDone)) begin
                        if (cmdTrigger) begin
                            cmdAccepted <= 1'b1;
                            datArm <= 1'b1;
                        end else begin
                            txStart <= 1'b1;
                            state <= sendStop;
                        end
                    end
                end
                sendStop: begin
                    if (txDone) begin
                        respArm <= 1'b1;
                        state <= waitStopResp;
                    end
                end
                waitStopResp: begin
                    if (respDone) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase

            // Sticky until reset
            if (respErr || datErr) begin
                err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && cmdTrigger) begin
            addrReg <= cmdAddr;
        end
    end

endmodule

`default_nettype wire

// ==== source/sdDatRx.sv ====
// Data block receiver for 4-bit DAT, one CRC16 per lane, 16-bit word output
`default_nettype none

module sdDatRx #(
    parameter int blockWords = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       datArm,
    input  logic [sdPkg::datLanes-1:0] datIn,
    output logic [sdPkg::wordBits-1:0] dataOut,
    output logic                       dataOutValid,
    output logic                       blockDone,
    output logic                       datErr
);
    import sdPkg::*;

    localparam int blockNibbles = blockWords * nibblesPerWord;
    localparam int cntBits = $clog2(blockNibbles);
    localparam int posBits = $clog2(nibblesPerWord);
    localparam int crcCntBits = $clog2(crc16Bits);

    typedef enum logic [2:0] {
        datIdle,
        datWaitStart,
        datData,
        datCrc,
        datEnd
    } datStateType;

    datStateType                  state;
    logic [cntBits-1:0]           nibCount;
    logic [crcCntBits-1:0]        crcCount;
    logic                         crcBad;
    logic                         wordEnd;
    logic [wordBits-datLanes-1:0] wordReg;
    logic [datLanes-1:0]          crcMiss;
    logic [crc16Bits-1:0]         laneCrc [datLanes];

    assign wordEnd = nibCount[posBits-1:0] == posBits'(nibblesPerWord - 1);

    // ============================================================
    // Lane CRCs
    // ============================================================

    for (genvar lane = 0; lane < datLanes; lane++) begin : gLane
        crc16 laneCrcGen (
            .clk     (clk),
            .rst     (rst),
            .clear   (state == datWaitStart),
            .shiftEn (state == datData),
            .din     (datIn[lane]),
            .crc     (laneCrc[lane])
        );
    end

    // Received CRC arrives MSB first on each lane
    always_comb begin
        for (int i = 0; i < datLanes; i++) begin
            crcMiss[i] = datIn[i] != laneCrc[i][crcCntBits'(crc16Bits - 1) - crcCount];
        end
    end

    // ============================================================
    // Block sequencing
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= datIdle;
            nibCount <= '0;
            crcCount <= '0;
            crcBad <= 1'b0;
            dataOutValid <= 1'b0;
            blockDone <= 1'b0;
            datErr <= 1'b0;
        end else begin
            dataOutValid <= 1'b0;
            blockDone <= 1'b0;
            datErr <= 1'b0;
            case (state)
                datIdle: begin
                    if (datArm) begin
                        state <= datWaitStart;
                    end
                end
                // Start bit on DAT0 stands for all lanes
                datWaitStart: begin
                    if (!datIn[0]) begin
                        state <= datData;
                        nibCount <= '0;
                    end
                end
                datData: begin
                    nibCount <= nibCount + 1'b1;
                    dataOutValid <= wordEnd;
                    if (nibCount == cntBits'(blockNibbles - 1)) begin
                        state <= datCrc;
                        crcCount <= '0;
                        crcBad <= 1'b0;
                    end
                end
                datCrc: begin
                    crcCount <= crcCount + 1'b1;
                    crcBad <= crcBad || (|crcMiss);
                    if (crcCount == crcCntBits'(crc16Bits - 1)) begin
                        state <= datEnd;
                    end
                end
                datEnd: begin
                    state <= datIdle;
                    blockDone <= 1'b1;
                    datErr <= crcBad || !(&datIn);
                end
                default: state <= datIdle;
            endcase
        end
    end

    // First nibble of a word lands in the top bits
    always_ff @(posedge clk) begin
        if (state == datData) begin
            wordReg <= {wordReg[wordBits-2*datLanes-1:0], datIn};
            if (wordEnd) begin
                dataOut <= {wordReg, datIn};
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/sdRespRx.sv ====
// Response receiver for the CMD line, checks framing and CRC7
`default_nettype none

module sdRespRx (
    input  logic clk,
    input  logic rst,
    input  logic respArm,
    input  logic cmdIn,
    output logic respDone,
    output logic respErr
);
    import sdPkg::*;

    localparam int cntBits = $clog2(cmdFrameBits);
    // Start, transmission, index and payload are covered by the CRC
    localparam int crcSpan = cmdFrameBits - crc7Bits - 1;

    typedef enum logic [1:0] {
        respIdle,
        respWaitStart,
        respShift
    } rxStateType;

    rxStateType              state;
    logic [cmdFrameBits-2:0] rxReg;
    logic [cntBits-1:0]      rxCount;
    logic [cmdFrameBits-1:0] frame;
    logic                    takeBit;
    logic                    crcClear;
    logic [crc7Bits-1:0]     crc;

    assign takeBit = (state == respWaitStart && !cmdIn) || state == respShift;
    // CRC stays cleared until the start bit shows up
    assign crcClear = state == respIdle || (state == respWaitStart && cmdIn);
    // Full frame in the cycle of the end bit
    assign frame = {rxReg, cmdIn};

    crc7 respCrc (
        .clk     (clk),
        .rst     (rst),
        .clear   (crcClear),
        .shiftEn (takeBit && rxCount < cntBits'(crcSpan)),
        .din     (cmdIn),
        .crc     (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= respIdle;
            rxCount <= '0;
            respDone <= 1'b0;
            respErr <= 1'b0;
        end else begin
            respDone <= 1'b0;
            respErr <= 1'b0;
            case (state)
                respIdle: begin
                    if (respArm) begin
                        state <= respWaitStart;
                        rxCount <= '0;
                    end
                end
                respWaitStart: begin
                    if (!cmdIn) begin
                        state <= respShift;
                        rxCount <= cntBits'(1);
                    end
                end
                respShift: begin
                    rxCount <= rxCount + 1'b1;
                    if (rxCount == cntBits'(cmdFrameBits - 1)) begin
                        state <= respIdle;
                        respDone <= 1'b1;
                        // Transmission bit 0, end bit 1, CRC in bits 7..1
                        respErr <= frame[cmdFrameBits-2] || !frame[0] ||
                                   frame[crc7Bits:1] != crc;
                    end
                end
                default: state <= respIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (takeBit) begin
            rxReg <= {rxReg[cmdFrameBits-3:0], cmdIn};
        end
    end

endmodule

`default_nettype wire

// ==== source/sdCmdTx.sv ====
// Command frame serializer for the CMD line, CRC7 filled in on the fly
`default_nettype none

module sdCmdTx (
    input  logic             clk,
    input  logic             rst,
    input  logic             txStart,
    input  sdPkg::sdCmdFrame txFrame,
    output logic             txDone,
    output sdPkg::sdCmdLine  cmdLine
);
    import sdPkg::*;

    localparam int cntBits = $clog2(cmdFrameBits);
    localparam int crcIdxBits = $clog2(crc7Bits);

    logic [cmdFrameBits-1:0] shiftReg;
    logic [cntBits-1:0]      bitCount;
    logic                    active;
    logic                    load;
    logic                    crcField;
    logic [crcIdxBits-1:0]   crcIdx;
    logic [crc7Bits-1:0]     crc;

    assign load = txStart && !active;
    // Frame bits 7..1 come from the CRC in MSB-first order
    assign crcField = active && bitCount != '0 && bitCount <= cntBits'(crc7Bits);
    assign crcIdx = crcIdxBits'(bitCount - 1'b1);

    assign cmdLine.cmdOut = crcField ? crc[crcIdx] : shiftReg[cmdFrameBits-1];
    assign cmdLine.cmdOutActive = active;

    // CRC runs over start, transmission, index and argument
    crc7 frameCrc (
        .clk     (clk),
        .rst     (rst),
        .clear   (load),
        .shiftEn (active && bitCount > cntBits'(crc7Bits)),
        .din     (shiftReg[cmdFrameBits-1]),
        .crc     (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            bitCount <= '0;
            txDone <= 1'b0;
        end else begin
            txDone <= 1'b0;
            if (load) begin
                active <= 1'b1;
                bitCount <= cntBits'(cmdFrameBits - 1);
            end else if (active) begin
                bitCount <= bitCount - 1'b1;
                // End bit is on the line
                if (bitCount == '0) begin
                    active <= 1'b0;
                    txDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shiftReg <= {2'b01, txFrame, {crc7Bits{1'b0}}, 1'b1};
        end else if (active) begin
            shiftReg <= shiftReg << 1;
        end
    end

endmodule

`default_nettype wire

// ==== source/crc16.sv ====
// Serial CRC16-CCITT generator, x^16 + x^12 + x^5 + 1
`default_nettype none

module crc16 (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        shiftEn,
    input  logic                        din,
    output logic [sdPkg::crc16Bits-1:0] crc
);
    import sdPkg::*;

    logic feedback;

    assign feedback = din ^ crc[crc16Bits-1];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= '0;
        end else if (shiftEn) begin
            // Taps at x^12, x^5 and x^0
            crc <= {crc[crc16Bits-2:0], 1'b0} ^ (feedback ? 16'h1021 : 16'h0000);
        end
    end

endmodule

`default_nettype wire

// ==== source/crc7.sv ====
// Serial CRC7 generator, x^7 + x^3 + 1
`default_nettype none

module crc7 (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       shiftEn,
    input  logic                       din,
    output logic [sdPkg::crc7Bits-1:0] crc
);
    import sdPkg::*;

    logic feedback;

    assign feedback = din ^ crc[crc7Bits-1];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= '0;
        end else if (shiftEn) begin
            // Taps at x^3 and x^0
            crc <= {crc[crc7Bits-2:0], 1'b0} ^ (feedback ? 7'h09 : 7'h00);
        end
    end

endmodule

`default_nettype wire

// ==== source/sdPkg.sv ====
// SD bus constants, command index enum and the packed structs
// shared by the read-path modules
`default_nettype none

package sdPkg;

    // ============================================================
    // Bus geometry
    // ============================================================

    // One command or response frame on CMD
    localparam int cmdFrameBits = 48;
    localparam int crc7Bits = 7;
    localparam int crc16Bits = 16;

    localparam int datLanes = 4;
    localparam int wordBits = 16;
    // Four DAT samples make one delivered word
    localparam int nibblesPerWord = 4;

    // ============================================================
    // Commands
    // ============================================================

    typedef enum logic [5:0] {
        cmdStopTransmission = 6'd12,
        cmdReadMultiple     = 6'd18
    } sdCmdIdx;

    // Framing and CRC are added by the serializer
    typedef struct packed {
        sdCmdIdx     index;
        logic [31:0] arg;
    } sdCmdFrame;

    // Host side of the CMD pin
    typedef struct packed {
        logic cmdOut;
        logic cmdOutActive;
    } sdCmdLine;

endpackage

`default_nettype wire
